/* design/alu_exec.sv */
////////////////////////////////////////
// Third stage. Integer ALU and the retire
// register, which also drives writeback.
////////////////////////////////////////

module alu_exec (
  input  logic                      clock,
  input  logic                      reset,
  input  pipe_pkg::exec_t           exe,
  output logic                      alu_valid,
  output logic                      alu_write,
  output pipe_pkg::reg_index_t      alu_rd,
  output logic [isa_pkg::xlen-1:0]  alu_result,
  output logic                      retire_valid,
  output pipe_pkg::retire_t         retire
);

  import isa_pkg::*;
  import pipe_pkg::*;

  logic [xlen-1:0]    a;
  logic [xlen-1:0]    b;
  logic [shamt_w-1:0] shamt;
  logic               lt_signed;
  logic               lt_unsigned;

  assign a           = exe.operand_a;
  assign b           = exe.operand_b;
  assign shamt       = b[shamt_w-1:0];
  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb begin
    case (exe.alu_op)
      alu_add:    alu_result = a + b;
      alu_sub:    alu_result = a - b;
      alu_sll:    alu_result = a << shamt;
      alu_slt:    alu_result = {{(xlen-1){1'b0}}, lt_signed};
      alu_sltu:   alu_result = {{(xlen-1){1'b0}}, lt_unsigned};
      alu_xor:    alu_result = a ^ b;
      alu_srl:    alu_result = a >> shamt;
      alu_sra:    alu_result = $signed(a) >>> shamt;
      alu_or:     alu_result = a | b;
      alu_and:    alu_result = a & b;
      alu_pass_b: alu_result = b;
      default:    alu_result = '0;
    endcase
    // illegal ops retire with zero
    if (exe.illegal)
      alu_result = '0;
  end

  // youngest bypass level
  assign alu_valid = exe.valid;
  assign alu_write = exe.write;
  assign alu_rd    = exe.rd;

  always_ff @(posedge clock) begin
    if (reset)
      retire_valid <= 1'b0;
    else
      retire_valid <= exe.valid;
  end

  always_ff @(posedge clock) begin
    retire.illegal <= exe.illegal;
    retire.rd      <= exe.rd;
    retire.write   <= exe.write;
    retire.value   <= alu_result;
  end

endmodule

/* design/core.sv */
////////////////////////////////////////
// Scalar in-order RV32I integer core.
// Decode, operand read and ALU in a fixed
// three-stage pipe, retiring two cycles
// after the instruction is sampled.
////////////////////////////////////////

module core (
  input  logic               clock,
  input  logic               reset,
  input  logic               inst_valid,
  input  isa_pkg::inst_t     inst,
  output logic               retire_valid,
  output pipe_pkg::retire_t  retire
);

  import isa_pkg::*;
  import pipe_pkg::*;

  uop_t            uop;
  exec_t           exe;
  logic            alu_valid;
  logic            alu_write;
  reg_index_t      alu_rd;
  logic [xlen-1:0] alu_result;

  inst_decode u_decode (
    .clock      (clock),
    .reset      (reset),
    .inst_valid (inst_valid),
    .inst       (inst),
    .uop        (uop)
  );

  // retire loops back as the writeback port
  operand_read u_operand (
    .clock        (clock),
    .reset        (reset),
    .uop          (uop),
    .alu_valid    (alu_valid),
    .alu_write    (alu_write),
    .alu_rd       (alu_rd),
    .alu_result   (alu_result),
    .retire_valid (retire_valid),
    .retire       (retire),
    .exe          (exe)
  );

  alu_exec u_alu (
    .clock        (clock),
    .reset        (reset),
    .exe          (exe),
    .alu_valid    (alu_valid),
    .alu_write    (alu_write),
    .alu_rd       (alu_rd),
    .alu_result   (alu_result),
    .retire_valid (retire_valid),
    .retire       (retire)
  );

endmodule

/* design/inst_decode.sv */
////////////////////////////////////////
// First stage. Decodes an RV32I word into
// a registered micro-op for operand read.
////////////////////////////////////////

module inst_decode (
  input  logic            clock,
  input  logic            reset,
  input  logic            inst_valid,
  input  isa_pkg::inst_t  inst,
  output pipe_pkg::uop_t  uop
);

  import isa_pkg::*;
  import pipe_pkg::*;

  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [xlen-1:0] i_imm;
  logic [xlen-1:0] shamt_imm;
  logic [xlen-1:0] u_imm;
  logic            legal;
  uop_t            uop_next;

  assign opcode    = inst[6:0];
  assign funct3    = inst[14:12];
  assign funct7    = inst[31:25];
  assign i_imm     = {{(xlen-12){inst[31]}}, inst[31:20]};
  assign shamt_imm = {{(xlen-shamt_w){1'b0}}, inst[20 +: shamt_w]};
  assign u_imm     = {inst[31:12], 12'b0};

  // operation for the funct7 == 0 forms
  function automatic alu_op_t base_op(logic [2:0] f3);
    case (f3)
      funct3_add_sub: return alu_add;
      funct3_sll:     return alu_sll;
      funct3_slt:     return alu_slt;
      funct3_sltu:    return alu_sltu;
      funct3_xor:     return alu_xor;
      funct3_srl_sra: return alu_srl;
      funct3_or:      return alu_or;
      default:        return alu_and;
    endcase
  endfunction

  always_comb begin
    uop_next         = '0;
    uop_next.valid   = inst_valid;
    uop_next.rs1     = inst[19:15];
    uop_next.rs2     = inst[24:20];
    uop_next.rd      = inst[11:7];
    uop_next.alu_op  = alu_add;
    legal            = 1'b0;
    case (opcode)
      opcode_op: begin
        if (funct7 == funct7_base) begin
          legal           = 1'b1;
          uop_next.alu_op = base_op(funct3);
        end else if (funct7 == funct7_alt &&
                     (funct3 == funct3_add_sub || funct3 == funct3_srl_sra)) begin
          legal           = 1'b1;
          uop_next.alu_op = (funct3 == funct3_add_sub) ? alu_sub : alu_sra;
        end
      end
      opcode_op_imm: begin
        uop_next.use_imm = 1'b1;
        uop_next.alu_op  = base_op(funct3);
        if (funct3 == funct3_sll || funct3 == funct3_srl_sra) begin
          // shifts carry the amount in the rs2 field
          uop_next.imm = shamt_imm;
          legal        = (funct7 == funct7_base) ||
                         (funct3 == funct3_srl_sra && funct7 == funct7_alt);
          if (funct7 == funct7_alt)
            uop_next.alu_op = alu_sra;
        end else begin
          uop_next.imm = i_imm;
          legal        = 1'b1;
        end
      end
      opcode_lui: begin
        legal            = 1'b1;
        uop_next.use_imm = 1'b1;
        uop_next.imm     = u_imm;
        uop_next.alu_op  = alu_pass_b;
      end
      default: legal = 1'b0;
    endcase
    uop_next.illegal = !legal;
    // later stages rely on write staying low for x0
    uop_next.write   = legal && (uop_next.rd != '0);
  end

  always_ff @(posedge clock) begin
    uop <= uop_next;
    if (reset)
      uop.valid <= 1'b0;
  end

endmodule

/* design/isa_pkg.sv */
////////////////////////////////////////
// RV32I encodings for the integer subset:
// opcodes, function codes and ALU operations.
// Shared by decode, execute and the testbench model.
////////////////////////////////////////

package isa_pkg;

  localparam int xlen = 32;
  localparam int shamt_w = 5;

  typedef logic [31:0] inst_t;

  // major opcodes
  localparam logic [6:0] opcode_op     = 7'b0110011;
  localparam logic [6:0] opcode_op_imm = 7'b0010011;
  localparam logic [6:0] opcode_lui    = 7'b0110111;

  localparam logic [2:0] funct3_add_sub = 3'b000;
  localparam logic [2:0] funct3_sll     = 3'b001;
  localparam logic [2:0] funct3_slt     = 3'b010;
  localparam logic [2:0] funct3_sltu    = 3'b011;
  localparam logic [2:0] funct3_xor     = 3'b100;
  localparam logic [2:0] funct3_srl_sra = 3'b101;
  localparam logic [2:0] funct3_or      = 3'b110;
  localparam logic [2:0] funct3_and     = 3'b111;

  // alt selects sub and sra
  localparam logic [6:0] funct7_base = 7'b0000000;
  localparam logic [6:0] funct7_alt  = 7'b0100000;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b
  } alu_op_t;

endpackage

/* design/operand_read.sv */
////////////////////////////////////////
// Second stage. Register file with its
// writeback port, two bypass levels and
// the registered operands for the ALU.
////////////////////////////////////////

module operand_read (
  input  logic                      clock,
  input  logic                      reset,
  input  pipe_pkg::uop_t            uop,
  input  logic                      alu_valid,
  input  logic                      alu_write,
  input  pipe_pkg::reg_index_t      alu_rd,
  input  logic [isa_pkg::xlen-1:0]  alu_result,
  input  logic                      retire_valid,
  input  pipe_pkg::retire_t         retire,
  output pipe_pkg::exec_t           exe
);

  import isa_pkg::*;
  import pipe_pkg::*;

  logic [xlen-1:0] regs [reg_count];
  logic [xlen-1:0] rs1_value;
  logic [xlen-1:0] rs2_value;
  exec_t           exe_next;

  // youngest producer wins
  function automatic logic [xlen-1:0] read_src(reg_index_t idx);
    if (alu_valid && alu_write && alu_rd == idx)
      return alu_result;
    else if (retire_valid && retire.write && retire.rd == idx)
      return retire.value;
    else
      return regs[idx];
  endfunction

  // writeback from the retire register
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < reg_count; i++)
        regs[i] <= '0;
    end else if (retire_valid && retire.write) begin
      regs[retire.rd] <= retire.value;
    end
  end

  always_comb begin
    rs1_value          = read_src(uop.rs1);
    rs2_value          = read_src(uop.rs2);
    exe_next.valid     = uop.valid;
    exe_next.illegal   = uop.illegal;
    exe_next.alu_op    = uop.alu_op;
    exe_next.operand_a = rs1_value;
    exe_next.operand_b = uop.use_imm ? uop.imm : rs2_value;
    exe_next.rd        = uop.rd;
    exe_next.write     = uop.write;
  end

  always_ff @(posedge clock) begin
    exe <= exe_next;
    if (reset)
      exe.valid <= 1'b0;
  end

endmodule

/* design/pipe_pkg.sv */
////////////////////////////////////////
// Stage payloads of the three-stage core
// and the register file sizing.
////////////////////////////////////////

package pipe_pkg;

  localparam int reg_count   = 32;
  localparam int reg_index_w = 5;

  typedef logic [reg_index_w-1:0] reg_index_t;

  // decode to operand read
  typedef struct packed {
    logic                      valid;
    logic                      illegal;
    isa_pkg::alu_op_t          alu_op;
    reg_index_t                rs1;
    reg_index_t                rs2;
    logic                      use_imm;
    logic [isa_pkg::xlen-1:0]  imm;
    reg_index_t                rd;
    logic                      write;
  } uop_t;

  // operand read to execute
  typedef struct packed {
    logic                      valid;
    logic                      illegal;
    isa_pkg::alu_op_t          alu_op;
    logic [isa_pkg::xlen-1:0]  operand_a;
    logic [isa_pkg::xlen-1:0]  operand_b;
    reg_index_t                rd;
    logic                      write;
  } exec_t;

  // retired result, also the writeback port
  typedef struct packed {
    logic                      illegal;
    reg_index_t                rd;
    logic                      write;
    logic [isa_pkg::xlen-1:0]  value;
  } retire_t;

endpackage

/* list.f */
+incdir+verif
design/isa_pkg.sv
design/pipe_pkg.sv
design/inst_decode.sv
design/operand_read.sv
design/alu_exec.sv
design/core.sv
verif/core_tb.sv

/* verif/core_ref.svh */
////////////////////////////////////////
// Reference model of the register file and
// the RV32I integer rules. Included into the
// testbench module body after the imports.
////////////////////////////////////////

`ifndef core_ref_svh
`define core_ref_svh

logic [xlen-1:0] ref_regs [reg_count];

function automatic void clear_model_regs();
  for (int i = 0; i < reg_count; i++)
    ref_regs[i] = '0;
endfunction

// steps one instruction in program order and returns what must retire
function automatic retire_t predict_retire(inst_t w);
  logic [6:0]      opcode;
  logic [2:0]      f3;
  logic [6:0]      f7;
  logic [xlen-1:0] a;
  logic [xlen-1:0] b;
  logic            alt;
  logic            ok;
  logic [xlen-1:0] value;
  retire_t         res;
  opcode = w[6:0];
  f3     = w[14:12];
  f7     = w[31:25];
  a      = ref_regs[w[19:15]];
  b      = '0;
  alt    = 1'b0;
  ok     = 1'b0;
  value  = '0;
  if (opcode == opcode_op) begin
    b   = ref_regs[w[24:20]];
    alt = (f7 == funct7_alt);
    ok  = (f7 == funct7_base) || (alt && (f3 == 3'd0 || f3 == 3'd5));
  end else if (opcode == opcode_op_imm) begin
    b = {{20{w[31]}}, w[31:20]};
    if (f3 == 3'd1) begin
      ok = (f7 == funct7_base);
    end else if (f3 == 3'd5) begin
      ok  = (f7 == funct7_base) || (f7 == funct7_alt);
      alt = (f7 == funct7_alt);
    end else begin
      ok = 1'b1;
    end
  end
  if (opcode == opcode_op || opcode == opcode_op_imm) begin
    case (f3)
      3'd0: value = alt ? a - b : a + b;
      3'd1: value = a << b[4:0];
      3'd2: value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3: value = (a < b) ? 32'd1 : 32'd0;
      3'd4: value = a ^ b;
      3'd5: value = alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6: value = a | b;
      default: value = a & b;
    endcase
  end else if (opcode == opcode_lui) begin
    ok    = 1'b1;
    value = {w[31:12], 12'h000};
  end
  if (!ok)
    value = '0;
  res.illegal = !ok;
  res.rd      = w[11:7];
  res.write   = ok && (w[11:7] != 5'd0);
  res.value   = value;
  if (res.write)
    ref_regs[res.rd] = value;
  return res;
endfunction

`endif

/* verif/core_tb.sv */
////////////////////////////////////////
// Testbench for the core. Random integer
// traffic checked against the model for
// value and two-cycle retire timing.
////////////////////////////////////////

module core_tb;

  timeunit 1ns;
  timeprecision 100ps;

  import isa_pkg::*;
  import pipe_pkg::*;

  localparam int inst_total   = 2000;
  localparam int reset_cycles = 16;
  localparam int wait_limit   = 64;

  logic    clock;
  logic    reset;
  logic    inst_valid;
  inst_t   inst;
  logic    retire_valid;
  retire_t retire;

  integer  seed;
  int      cycle;
  retire_t exp_q[$];
  int      due_q[$];

  `include "core_ref.svh"

  core u_dut (
    .clock        (clock),
    .reset        (reset),
    .inst_valid   (inst_valid),
    .inst         (inst),
    .retire_valid (retire_valid),
    .retire       (retire)
  );

  always #5 clock = ~clock;

  always @(posedge clock)
    cycle <= cycle + 1;

  task automatic abort_run(string detail);
    $display("%s", detail);
    $display("tests failed");
    $fatal(1);
  endtask

  function automatic string describe_retire(retire_t r);
    return $sformatf("illegal=%0b rd=%0d write=%0b value=%h",
                     r.illegal, r.rd, r.write, r.value);
  endfunction

  task automatic check_flag(string name, logic expected, logic actual);
    if (actual !== expected)
      abort_run($sformatf("error at %0t ns: %s expected %0b actual %0b",
                          $time, name, expected, actual));
  endtask

  task automatic check_retire(retire_t expected, retire_t actual);
    if (actual !== expected)
      abort_run($sformatf("error at %0t ns: retire expected %s actual %s",
                          $time, describe_retire(expected),
                          describe_retire(actual)));
  endtask

  function automatic int rand_below(int n);
    return ($random(seed) & 32'h7fff_ffff) % n;
  endfunction

  // mostly x0..x7 so dependences are frequent
  function automatic reg_index_t pick_reg();
    reg_index_t r;
    if (rand_below(8) != 0)
      r = reg_index_t'(rand_below(8));
    else
      r = reg_index_t'(rand_below(32));
    return r;
  endfunction

  function automatic inst_t make_inst();
    int         kind;
    logic [2:0] f3;
    logic [6:0] f7;
    inst_t      w;
    kind = rand_below(16);
    f3   = 3'(rand_below(8));
    f7   = funct7_base;
    w    = $random(seed);
    if (kind < 6) begin
      if (rand_below(2) == 1 && (f3 == 3'd0 || f3 == 3'd5))
        f7 = funct7_alt;
      w = {f7, pick_reg(), pick_reg(), f3, pick_reg(), opcode_op};
    end else if (kind < 12) begin
      // shift amount stays random in the rs2 field
      if (f3 == 3'd1 || f3 == 3'd5)
        w[31:25] = (f3 == 3'd5 && rand_below(2) == 1) ? funct7_alt : funct7_base;
      w[19:0] = {pick_reg(), f3, pick_reg(), opcode_op_imm};
    end else if (kind < 14) begin
      w[11:0] = {pick_reg(), opcode_lui};
    end else if (kind == 14) begin
      w[6:0] = 7'b0000011;
    end else begin
      f7 = 7'(rand_below(127) + 1);
      w  = {f7, pick_reg(), pick_reg(), f3, pick_reg(), opcode_op};
    end
    return w;
  endfunction

  initial begin
    reset = 1'b1;
    repeat (reset_cycles) @(posedge clock);
    reset <= 1'b0;
  end

  initial begin
    int    accepted;
    int    waited;
    logic  go;
    inst_t w;
    clock      = 1'b0;
    inst_valid = 1'b0;
    inst       = '0;
    seed       = 34483;
    cycle      = 0;
    accepted   = 0;
    waited     = 0;
    clear_model_regs();
    while (reset !== 1'b0) begin
      @(posedge clock);
      waited++;
      if (waited > wait_limit)
        abort_run("reset was never released");
    end
    while (accepted < inst_total) begin
      @(posedge clock);
      go = (rand_below(4) != 0);
      w  = make_inst();
      inst_valid <= go;
      inst       <= w;
      if (go) begin
        exp_q.push_back(predict_retire(w));
        // sampled at the next edge and retired two edges after that
        due_q.push_back(cycle + 4);
        accepted++;
      end
    end
    @(posedge clock);
    inst_valid <= 1'b0;
    waited = 0;
    while (exp_q.size() != 0) begin
      @(posedge clock);
      waited++;
      if (waited > wait_limit)
        abort_run("expected results never retired, queue did not drain");
    end
    $display("all tests passed");
    $finish;
  end

  // outputs are stable at the falling edge
  always @(negedge clock) begin : check_outputs
    logic due_now;
    if (reset === 1'b0) begin
      due_now = (due_q.size() != 0) && (due_q[0] == cycle);
      check_flag("retire_valid", due_now, retire_valid);
      if (due_now) begin
        check_retire(exp_q[0], retire);
        void'(exp_q.pop_front());
        void'(due_q.pop_front());
      end
    end
  end

endmodule
